//--- src/sched_pkg.sv
/*
  Shared types and sizing for the four-bank DRAM command scheduler.
  Modules import this package inside their bodies and use scoped names
  (sched_pkg::name) in their port lists.
*/
`default_nettype none

package sched_pkg;

  ////////////////////
  // Sizing

  localparam int NUM_BANKS     = 4;
  localparam int BANK_ID_WIDTH = 2;
  localparam int ADDR_WIDTH    = 14;
  localparam int AGE_WIDTH     = 8;
  localparam int ISSUE_CREDITS = 4;
  localparam int CREDIT_WIDTH  = 3;

  // Streak limits for class arbitration
  localparam int ACT_BURST_MAX = 3;
  localparam int RW_BURST_MAX  = 4;
  localparam int STREAK_WIDTH  = 3;

  ////////////////////
  // Encodings

  // Per-bank FSM state as reported by the bank controllers
  typedef enum logic [3:0] {
    st_idle        = 4'd0,
    st_act_check   = 4'd1,
    st_write_check = 4'd2,
    st_read_check  = 4'd3,
    st_pre_check   = 4'd4,
    st_active      = 4'd5,
    st_read        = 4'd6,
    st_write       = 4'd7,
    st_pre         = 4'd8,
    st_act_standby = 4'd9
  } bank_state_e;

  // Command opcode sent to the issue queue
  typedef enum logic [3:0] {
    cmd_nop       = 4'd0,
    cmd_activate  = 4'd1,
    cmd_read      = 4'd2,
    cmd_write     = 4'd3,
    cmd_precharge = 4'd4
  } dram_cmd_e;

  typedef enum logic [1:0] {
    cls_pre   = 2'd0,
    cls_act   = 2'd1,
    cls_read  = 2'd2,
    cls_write = 2'd3
  } cmd_class_e;

  ////////////////////
  // Structs

  // 18 bits, state in the upper nibble
  typedef struct packed {
    bank_state_e             state;
    logic [ADDR_WIDTH-1:0]   addr;
  } bank_info_t;

  // 20 bits, one issue queue entry
  typedef struct packed {
    dram_cmd_e                cmd;
    logic [ADDR_WIDTH-1:0]    addr;
    logic [BANK_ID_WIDTH-1:0] bank;
  } sch_cmd_t;

endpackage

`default_nettype wire

//--- src/bank_age_counter.sv
/*
  Saturating age counter for one bank.
  Counts every cycle the bank has work in flight (check or ready state)
  and is cleared while the bank sits idle or in active standby.
  The age decides which bank wins inside a command class.
*/
`timescale 1ns/1ps
`default_nettype none

module bank_age_counter (
  input  logic                            clk,
  input  logic                            rst_n,
  input  sched_pkg::bank_state_e          state,
  output logic [sched_pkg::AGE_WIDTH-1:0] age
);

  import sched_pkg::*;

  logic idle_state;
  logic at_max;

  // No outstanding work in these two states
  assign idle_state = (state == st_idle) || (state == st_act_standby);
  assign at_max     = (age == {AGE_WIDTH{1'b1}});

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      age <= '0;
    end else if (idle_state) begin
      age <= '0;
    end else if (!at_max) begin
      age <= age + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/cmd_class_select.sv
/*
  Command class arbitration.
  Precharge first, then activate, then data. A run of activates is broken
  after ACT_BURST_MAX so one pending data command can go, and data keeps
  its direction until RW_BURST_MAX while the other direction waits.
  Streak counters advance on each grant of the chosen class.
*/
`timescale 1ns/1ps
`default_nettype none

module cmd_class_select (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  sched_pkg::bank_info_t [sched_pkg::NUM_BANKS-1:0] bank_info,
  input  logic                                             grant_valid,
  output sched_pkg::cmd_class_e                            issued_class,
  output logic                                             class_valid
);

  import sched_pkg::*;

  logic pend_pre;
  logic pend_act;
  logic pend_read;
  logic pend_write;
  logic data_pend;
  logic cur_pend;
  logic oth_pend;

  logic [STREAK_WIDTH-1:0] act_streak;
  logic [STREAK_WIDTH-1:0] rw_streak;
  logic                    dir_write;

  ////////////////////
  // Pending classes

  always_comb begin
    pend_pre   = 1'b0;
    pend_act   = 1'b0;
    pend_read  = 1'b0;
    pend_write = 1'b0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      pend_pre   |= (bank_info[i].state == st_pre);
      pend_act   |= (bank_info[i].state == st_active);
      pend_read  |= (bank_info[i].state == st_read);
      pend_write |= (bank_info[i].state == st_write);
    end
  end

  assign data_pend = pend_read | pend_write;
  assign cur_pend  = dir_write ? pend_write : pend_read;
  assign oth_pend  = dir_write ? pend_read : pend_write;

  ////////////////////
  // Class choice

  always_comb begin
    issued_class = cls_pre;
    class_valid  = pend_pre | pend_act | data_pend;
    if (pend_pre) begin
      issued_class = cls_pre;
    end else if (pend_act && !(act_streak >= ACT_BURST_MAX && data_pend)) begin
      issued_class = cls_act;
    end else if (data_pend) begin
      // Stay on the current direction unless it is empty or its run is used up
      if (cur_pend && !(rw_streak >= RW_BURST_MAX && oth_pend)) begin
        issued_class = dir_write ? cls_write : cls_read;
      end else begin
        issued_class = dir_write ? cls_read : cls_write;
      end
    end
  end

  ////////////////////
  // Streak tracking

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      act_streak <= '0;
      rw_streak  <= '0;
      dir_write  <= 1'b0;
    end else if (grant_valid) begin
      case (issued_class)
        cls_act: begin
          if (act_streak < ACT_BURST_MAX) begin
            act_streak <= act_streak + 1'b1;
          end
        end
        cls_read, cls_write: begin
          act_streak <= '0;
          if ((issued_class == cls_write) == dir_write) begin
            if (rw_streak < RW_BURST_MAX) begin
              rw_streak <= rw_streak + 1'b1;
            end
          end else begin
            rw_streak <= STREAK_WIDTH'(1);
            dir_write <= ~dir_write;
          end
        end
        default: begin
          // Precharge does not touch either run
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/oldest_bank_pick.sv
/*
  Oldest-bank selection within the chosen command class.
  Only banks in the ready state of that class compete; the greatest age
  wins and a tie goes to the lowest bank index. A grant also needs a free
  issue credit. Every bank without the grant is stalled.
*/
`timescale 1ns/1ps
`default_nettype none

module oldest_bank_pick (
  input  logic                                                 [sched_pkg::NUM_BANKS-1:0]
                                                               [sched_pkg::AGE_WIDTH-1:0] age,
  input  sched_pkg::bank_info_t [sched_pkg::NUM_BANKS-1:0]     bank_info,
  input  sched_pkg::cmd_class_e                                issued_class,
  input  logic                                                 class_valid,
  input  logic                                                 credit_avail,
  output logic [sched_pkg::NUM_BANKS-1:0]                      bank_grant,
  output logic [sched_pkg::NUM_BANKS-1:0]                      bank_stall,
  output logic                                                 grant_valid,
  output logic [sched_pkg::BANK_ID_WIDTH-1:0]                  grant_bank
);

  import sched_pkg::*;

  bank_state_e            want_state;
  logic                   found;
  logic [AGE_WIDTH-1:0]   best_age;

  // Ready state that matches the class
  always_comb begin
    case (issued_class)
      cls_act:   want_state = st_active;
      cls_read:  want_state = st_read;
      cls_write: want_state = st_write;
      default:   want_state = st_pre;
    endcase
  end

  ////////////////////
  // Age comparison

  always_comb begin
    found      = 1'b0;
    best_age   = '0;
    grant_bank = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      // Strict compare keeps the lower index on a tie
      if (bank_info[i].state == want_state && (!found || age[i] > best_age)) begin
        found      = 1'b1;
        best_age   = age[i];
        grant_bank = BANK_ID_WIDTH'(i);
      end
    end
  end

  assign grant_valid = found & class_valid & credit_avail;

  always_comb begin
    bank_grant = '0;
    if (grant_valid) begin
      bank_grant[grant_bank] = 1'b1;
    end
  end

  assign bank_stall = ~bank_grant;

endmodule

`default_nettype wire

//--- src/cmd_issue_stage.sv
/*
  Issue register and credit counter for the downstream issue queue.
  A grant spends one credit and, on the next cycle, presents the granted
  bank's command word with sch_issue high for one cycle. Each credit
  return pulse gives one credit back.
*/
`timescale 1ns/1ps
`default_nettype none

module cmd_issue_stage (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  sched_pkg::bank_info_t [sched_pkg::NUM_BANKS-1:0] bank_info,
  input  logic                                             grant_valid,
  input  logic [sched_pkg::BANK_ID_WIDTH-1:0]              grant_bank,
  input  logic                                             credit_return,
  output logic                                             credit_avail,
  output sched_pkg::sch_cmd_t                              sch_out,
  output logic                                             sch_issue
);

  import sched_pkg::*;

  logic [CREDIT_WIDTH-1:0] credits;
  bank_info_t              sel_info;
  dram_cmd_e               sel_cmd;

  ////////////////////
  // Credits

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= CREDIT_WIDTH'(ISSUE_CREDITS);
    end else begin
      case ({grant_valid, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  assign credit_avail = (credits != '0);

  ////////////////////
  // Command word

  assign sel_info = bank_info[grant_bank];

  always_comb begin
    case (sel_info.state)
      st_active: sel_cmd = cmd_activate;
      st_read:   sel_cmd = cmd_read;
      st_write:  sel_cmd = cmd_write;
      st_pre:    sel_cmd = cmd_precharge;
      default:   sel_cmd = cmd_nop;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sch_issue <= 1'b0;
    end else begin
      sch_issue <= grant_valid;
    end
  end

  // Word holds between issues
  always_ff @(posedge clk) begin
    if (grant_valid) begin
      sch_out.cmd  <= sel_cmd;
      sch_out.addr <= sel_info.addr;
      sch_out.bank <= grant_bank;
    end
  end

endmodule

`default_nettype wire

//--- src/cmd_scheduler.sv
/*
  Four-bank DRAM command scheduler, top level.
  Per-bank age counters feed the class arbiter and the oldest-bank pick;
  the winner's command goes to the issue queue one cycle after the grant.
  Drive bank_info every cycle and pulse credit_return once per freed
  queue entry.
*/
`timescale 1ns/1ps
`default_nettype none

module cmd_scheduler (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  sched_pkg::bank_info_t [sched_pkg::NUM_BANKS-1:0] bank_info,
  input  logic                                             credit_return,
  output logic [sched_pkg::NUM_BANKS-1:0]                  bank_stall,
  output sched_pkg::sch_cmd_t                              sch_out,
  output logic                                             sch_issue
);

  import sched_pkg::*;

  logic [NUM_BANKS-1:0][AGE_WIDTH-1:0] age;
  cmd_class_e                          issued_class;
  logic                                class_valid;
  logic                                credit_avail;
  logic                                grant_valid;
  logic [BANK_ID_WIDTH-1:0]            grant_bank;

  ////////////////////
  // Bank ages

  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_age
    bank_age_counter u_age (
      .clk   (clk),
      .rst_n (rst_n),
      .state (bank_info[g].state),
      .age   (age[g])
    );
  end

  ////////////////////
  // Arbitration

  cmd_class_select u_class (
    .clk          (clk),
    .rst_n        (rst_n),
    .bank_info    (bank_info),
    .grant_valid  (grant_valid),
    .issued_class (issued_class),
    .class_valid  (class_valid)
  );

  // One-hot grant only feeds the stalls
  oldest_bank_pick u_pick (
    .age          (age),
    .bank_info    (bank_info),
    .issued_class (issued_class),
    .class_valid  (class_valid),
    .credit_avail (credit_avail),
    .bank_grant   (),
    .bank_stall   (bank_stall),
    .grant_valid  (grant_valid),
    .grant_bank   (grant_bank)
  );

  ////////////////////
  // Issue

  cmd_issue_stage u_issue (
    .clk           (clk),
    .rst_n         (rst_n),
    .bank_info     (bank_info),
    .grant_valid   (grant_valid),
    .grant_bank    (grant_bank),
    .credit_return (credit_return),
    .credit_avail  (credit_avail),
    .sch_out       (sch_out),
    .sch_issue     (sch_issue)
  );

endmodule

`default_nettype wire

//--- testbench/tb_sched_model.svh
/*
  Cycle model of the scheduler for the testbench.
  Covers bank aging, class choice, the oldest-bank winner and the
  state-to-command mapping. Include it inside the testbench module,
  after the package import.
*/
`ifndef TB_SCHED_MODEL_SVH
`define TB_SCHED_MODEL_SVH

// Idle and standby banks restart at zero, others count up to the ceiling
function automatic int aged_value(input int age, input bank_state_e st);
  if (st == st_idle || st == st_act_standby) begin
    return 0;
  end
  return (age >= (1 << AGE_WIDTH) - 1) ? age : age + 1;
endfunction

// Class to serve, or -1 when nothing is ready
function automatic int pick_class(input bank_info_t [NUM_BANKS-1:0] info, input int act_run,
                                  input int rw_run, input bit on_write);
  int n_pre = 0;
  int n_act = 0;
  int n_rd = 0;
  int n_wr = 0;
  for (int b = 0; b < NUM_BANKS; b++) begin
    case (info[b].state)
      st_pre:    n_pre++;
      st_active: n_act++;
      st_read:   n_rd++;
      st_write:  n_wr++;
      default:   ;
    endcase
  end
  if (n_pre > 0) begin
    return cls_pre;
  end
  if (n_act > 0 && (act_run < ACT_BURST_MAX || n_rd + n_wr == 0)) begin
    return cls_act;
  end
  if (n_rd + n_wr == 0) begin
    return -1;
  end
  if (on_write) begin
    return (n_wr > 0 && (rw_run < RW_BURST_MAX || n_rd == 0)) ? cls_write : cls_read;
  end
  return (n_rd > 0 && (rw_run < RW_BURST_MAX || n_wr == 0)) ? cls_read : cls_write;
endfunction

// Winner inside the class, scanned downward so equal ages fall to the lower index
function automatic int oldest_ready_bank(input bank_info_t [NUM_BANKS-1:0] info,
                                         input int ages [NUM_BANKS], input int cls);
  bank_state_e want;
  int best = -1;
  want = (cls == cls_act) ? st_active : (cls == cls_read) ? st_read :
         (cls == cls_write) ? st_write : st_pre;
  for (int b = NUM_BANKS - 1; b >= 0; b--) begin
    if (info[b].state == want && (best < 0 || ages[b] >= ages[best])) begin
      best = b;
    end
  end
  return best;
endfunction

function automatic dram_cmd_e command_for_state(input bank_state_e st);
  case (st)
    st_active: return cmd_activate;
    st_read:   return cmd_read;
    st_write:  return cmd_write;
    st_pre:    return cmd_precharge;
    default:   return cmd_nop;
  endcase
endfunction

`endif

//--- testbench/tb_cmd_scheduler.sv
/*
  Testbench for the four-bank command scheduler.
  Drives bank states and addresses from an LCG, returns issue credits
  and checks stalls and issued command words against a cycle model.
  The run stops at the first mismatch.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_cmd_scheduler;

  import sched_pkg::*;

  `include "tb_sched_model.svh"

  localparam int RESET_CYCLES  = 10;
  localparam int IDLE_CYCLES   = 8;
  localparam int SINGLE_ROUNDS = 8;
  localparam int RANDOM_CYCLES = 60;
  localparam int MIX_CYCLES    = 16;
  localparam int HOLD_CYCLES   = 10;
  // Phases in order, then the tail
  localparam int TEST_CYCLES = RESET_CYCLES + IDLE_CYCLES + 2 * SINGLE_ROUNDS + 4 +
                               RANDOM_CYCLES + 3 + MIX_CYCLES + 5 + MIX_CYCLES +
                               6 + HOLD_CYCLES + 1 + 5 + 3;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                       clk = 1'b0;
  logic                       rst_n;
  bank_info_t [NUM_BANKS-1:0] bank_info;
  logic                       credit_return;
  logic [NUM_BANKS-1:0]       bank_stall;
  sch_cmd_t                   sch_out;
  logic                       sch_issue;

  // Model state for the cycle in progress
  int       m_age [NUM_BANKS];
  int       m_act_run;
  int       m_rw_run;
  bit       m_on_write;
  int       m_credits;
  bit       exp_issue;
  sch_cmd_t exp_word;
  int       grant_phase;

  int unsigned lcg_state   = 5857;
  int          cycle_count = 0;
  int          issue_count = 0;
  int          phase       = 0;
  bit          auto_return = 1'b1;

  cmd_scheduler UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .bank_info     (bank_info),
    .credit_return (credit_return),
    .bank_stall    (bank_stall),
    .sch_out       (sch_out),
    .sch_issue     (sch_issue)
  );

  always #4 clk = ~clk;

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "Stopping at first mismatch");
  endtask

  // Returns a credit whenever the queue holds one of ours
  task automatic drive_cycle(input bank_info_t [NUM_BANKS-1:0] info);
    @(posedge clk);
    bank_info     <= info;
    credit_return <= auto_return && (m_credits < ISSUE_CREDITS);
  endtask

  ////////////////////
  // Model and checks

  always @(negedge clk) begin
    int cls;
    int win;
    logic [NUM_BANKS-1:0] exp_stall;
    if (!rst_n) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        m_age[b] = 0;
      end
      m_act_run  = 0;
      m_rw_run   = 0;
      m_on_write = 1'b0;
      m_credits  = ISSUE_CREDITS;
      exp_issue  = 1'b0;
    end else begin
      cls = pick_class(bank_info, m_act_run, m_rw_run, m_on_write);
      win = (cls < 0 || m_credits == 0) ? -1 : oldest_ready_bank(bank_info, m_age, cls);
      exp_stall = '1;
      if (win >= 0) begin
        exp_stall[win] = 1'b0;
      end
      assert (bank_stall == exp_stall)
        else report_mismatch($sformatf("bank_stall %b, expected %b", bank_stall, exp_stall));
      assert (sch_issue == exp_issue)
        else report_mismatch($sformatf("sch_issue %b, expected %b", sch_issue, exp_issue));
      if (exp_issue) begin
        assert (sch_out == exp_word)
          else report_mismatch($sformatf("sch_out cmd %0d addr %h bank %0d, expected %0d %h %0d",
                                         sch_out.cmd, sch_out.addr, sch_out.bank,
                                         exp_word.cmd, exp_word.addr, exp_word.bank));
      end
      if (sch_issue && grant_phase == 6) begin
        issue_count++;
      end
      // Advance to the state after the coming edge
      exp_issue = (win >= 0);
      if (win >= 0) begin
        exp_word.cmd  = command_for_state(bank_info[win].state);
        exp_word.addr = bank_info[win].addr;
        exp_word.bank = BANK_ID_WIDTH'(win);
        grant_phase   = phase;
        case (cls)
          cls_act: m_act_run++;
          cls_read, cls_write: begin
            m_act_run = 0;
            if ((cls == cls_write) == m_on_write) begin
              m_rw_run++;
            end else begin
              m_rw_run   = 1;
              m_on_write = (cls == cls_write);
            end
          end
          default: ;
        endcase
      end
      for (int b = 0; b < NUM_BANKS; b++) begin
        m_age[b] = aged_value(m_age[b], bank_info[b].state);
      end
      m_credits = m_credits - ((win >= 0) ? 1 : 0) + (credit_return ? 1 : 0);
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $fatal(1, "Timeout");
    end
  end

  ////////////////////
  // Stimulus

  initial begin
    bank_info_t [NUM_BANKS-1:0] nxt;
    int pick;
    rst_n         = 1'b0;
    credit_return = 1'b0;
    bank_info     = '0;
    nxt           = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    phase = 1;
    repeat (IDLE_CYCLES) drive_cycle(nxt);

    // One ready bank at a time
    phase = 2;
    repeat (SINGLE_ROUNDS) begin
      pick = int'(next_rand() % NUM_BANKS);
      nxt[pick].state = bank_state_e'(4'(5 + next_rand() % 4));
      nxt[pick].addr  = ADDR_WIDTH'(next_rand());
      drive_cycle(nxt);
      nxt = '0;
      drive_cycle(nxt);
    end

    // Equal ages first, then a bank parked in a check state
    phase = 3;
    for (int b = 0; b < NUM_BANKS; b++) begin
      nxt[b].state = st_write;
      nxt[b].addr  = ADDR_WIDTH'(next_rand());
    end
    repeat (2) drive_cycle(nxt);
    nxt[0].state = st_write_check;
    repeat (2) drive_cycle(nxt);
    repeat (RANDOM_CYCLES) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (next_rand() % 4 == 0) begin
          nxt[b].state = bank_state_e'(4'(next_rand() % 10));
          nxt[b].addr  = ADDR_WIDTH'(next_rand());
        end
      end
      drive_cycle(nxt);
    end

    // Precharge first, then activate runs broken by reads
    phase = 4;
    for (int b = 0; b < NUM_BANKS; b++) begin
      nxt[b].state = st_idle;
      nxt[b].addr  = ADDR_WIDTH'(next_rand());
    end
    nxt[0].state = st_pre;
    nxt[1].state = st_active;
    nxt[2].state = st_read;
    drive_cycle(nxt);
    nxt[0].state = st_idle;
    nxt[1].state = st_idle;
    repeat (2) drive_cycle(nxt);
    nxt[1].state = st_active;
    nxt[3].state = st_active;
    repeat (MIX_CYCLES) drive_cycle(nxt);

    // Read and write runs
    phase = 5;
    for (int b = 0; b < NUM_BANKS; b++) begin
      nxt[b].state = st_idle;
    end
    nxt[0].state = st_write;
    repeat (5) drive_cycle(nxt);
    nxt[1].state = st_read;
    nxt[2].state = st_write_check;
    nxt[3].state = st_read;
    repeat (MIX_CYCLES) drive_cycle(nxt);

    // Credits run dry, then one return
    nxt = '0;
    repeat (6) drive_cycle(nxt);
    phase = 6;
    auto_return = 1'b0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      nxt[b].addr = ADDR_WIDTH'(next_rand());
    end
    nxt[0].state = st_read;
    nxt[1].state = st_write;
    nxt[2].state = st_active;
    nxt[3].state = st_pre;
    repeat (HOLD_CYCLES) drive_cycle(nxt);
    auto_return = 1'b1;
    drive_cycle(nxt);
    auto_return = 1'b0;
    repeat (5) drive_cycle(nxt);
    nxt = '0;
    repeat (3) drive_cycle(nxt);

    assert (issue_count == ISSUE_CREDITS + 1)
      else report_mismatch($sformatf("%0d issues on limited credits, expected %0d",
                                     issue_count, ISSUE_CREDITS + 1));
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- cmd_scheduler.f
+incdir+testbench
src/sched_pkg.sv
src/bank_age_counter.sv
src/cmd_class_select.sv
src/oldest_bank_pick.sv
src/cmd_issue_stage.sv
src/cmd_scheduler.sv
testbench/tb_cmd_scheduler.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the scheduler testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f cmd_scheduler.f \
  --top-module tb_cmd_scheduler -o sim_cmd_scheduler > build.log 2>&1 \
  && ./obj_dir/sim_cmd_scheduler > sim.log 2>&1 \
  || echo "Build or simulation exited with an error"
grep -qs "TESTS PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
